// File: logic/search_cfg.svh
`ifndef SEARCH_CFG_SVH
`define SEARCH_CFG_SVH

// Block width shared by message, key and ciphertext
`define SEARCH_W 64

// One Feistel half, also the width of each round key
`define HALF_W (`SEARCH_W/2)

// Left rotate applied inside the round function
// Must stay below HALF_W
`define ROT_AMT 7

`endif

// File: logic/search_data_pkg.sv
`include "search_cfg.svh"

package search_data_pkg;

    // Full width block, message or cipher text
    typedef logic [`SEARCH_W-1:0] block_t;

    // One Feistel half, same width as a round key
    typedef logic [`HALF_W-1:0] half_t;

    // Candidate moving down the pipeline
    typedef struct packed {
        logic   valid; // Qualifies the rest of the struct
        logic   last;  // Final candidate of the LFSR period
        block_t msg;   // Source message, never modified
        block_t blk;   // Working block, enciphered stage by stage
    } cand_t;

endpackage

// File: logic/search_ctrl_pkg.sv
package search_ctrl_pkg;

    // States of the candidate counter
    typedef enum logic [2:0] {
        cnt_idle     = 3'h0, // Seed and polynomial follow the inputs
        cnt_first    = 3'h1, // Seed itself goes out
        cnt_working  = 3'h2, // Stepping the LFSR
        cnt_paused   = 3'h3,
        cnt_finished = 3'h4  // Period exhausted
    } cnt_state_e;

    typedef logic [31:0] count_t; // Candidate and hit counters

    // Status seen from outside the search engine
    typedef struct packed {
        logic   done;  // Last candidate has left the match stage
        count_t tried; // Valid candidates compared so far
        count_t hits;  // Matches against the target
    } search_status_t;

endpackage

// File: logic/lfsr_counter.sv
`timescale 1ns/100ps
`include "search_cfg.svh"

// Galois LFSR candidate source
// Walks one full period starting from the seed and stops before the seed recurs
module lfsr_counter
    import search_data_pkg::*, search_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,         // Synchronous, active low
    input  logic       start,         // Level, sampled in idle
    input  logic       pause,         // Holds the source while high
    input  logic       reset_counter, // Abort, back to idle from any state
    input  block_t     seed,
    input  block_t     polynomial,
    output cand_t      cand,          // Combinational from state and register
    output cnt_state_e state
);

    cnt_state_e next_state;

    block_t lfsr_reg;  // Current LFSR value
    block_t lfsr_next; // Value after one step
    block_t seed_reg;  // Start point, also end of period marker
    block_t poly_reg;  // Feedback taps

    logic load_cfg; // Copy seed and polynomial in
    logic step;     // Advance the LFSR
    logic emit;     // Current register goes out as a candidate
    logic wrap;     // Next step lands on the seed again

    // One right shift, bit 0 fed back into the tapped positions and into the MSB
    function automatic block_t lfsr_step(input block_t cur, input block_t poly);
        block_t nxt;
        nxt[`SEARCH_W-1] = cur[0];
        for (int i = 0; i < `SEARCH_W-1; i++) begin
            nxt[i] = poly[i] ? (cur[i+1] ^ cur[0]) : cur[i+1];
        end
        return nxt;
    endfunction

    assign lfsr_next = lfsr_step(lfsr_reg, poly_reg);
    assign wrap      = (lfsr_next == seed_reg);

    always_ff @(posedge clk) begin // State register
        if (!rst_n) begin
            state <= cnt_idle;
        end else begin
            state <= next_state;
        end
    end

    // Next state and control strobes
    always_comb begin
        next_state = state;
        load_cfg   = 1'b0;
        step       = 1'b0;
        emit       = 1'b0;

        case (state)
            cnt_idle: begin
                load_cfg = 1'b1; // Follow the inputs until start
                if (start) begin
                    next_state = cnt_first;
                end
            end
            cnt_first: begin
                emit = 1'b1; // Seed is the first candidate
                step = 1'b1;
                // Period of one, e.g. all zero seed
                next_state = wrap ? cnt_finished : cnt_working;
            end
            cnt_working: begin
                if (pause) begin
                    next_state = cnt_paused; // Register holds, nothing emitted
                end else begin
                    emit = 1'b1;
                    step = 1'b1;
                    if (wrap) begin
                        next_state = cnt_finished; // Seed would come next
                    end
                end
            end
            cnt_paused: begin
                if (!pause) begin
                    next_state = cnt_working;
                end
            end
            cnt_finished: begin
                next_state = cnt_finished; // Wait for an abort
            end
            default: begin
                next_state = cnt_idle;
            end
        endcase

        // Abort wins over everything else
        if (reset_counter) begin
            next_state = cnt_idle;
            emit       = 1'b0;
            step       = 1'b0;
        end
    end

    always_ff @(posedge clk) begin // LFSR datapath
        if (load_cfg) begin
            lfsr_reg <= seed;
        end else if (step) begin
            lfsr_reg <= lfsr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_cfg) begin
            seed_reg <= seed;
            poly_reg <= polynomial;
        end
    end

    always_comb begin
        cand.valid = emit;
        cand.last  = emit & wrap; // Successor equals the seed
        cand.msg   = lfsr_reg;
        cand.blk   = lfsr_reg;    // Plain text enters the rounds
    end

    // No candidate may leave while the source is held or exhausted
    a_quiet_states: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state inside {cnt_paused, cnt_finished}) |-> !cand.valid
    ) else $error("lfsr_counter emitted a candidate in state %s", state.name());

endmodule

// File: logic/feistel_round.sv
`timescale 1ns/100ps
`include "search_cfg.svh"

// One registered Feistel round
// The source message and flags ride along with the block
module feistel_round
    import search_data_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  half_t round_key,
    input  cand_t in_cand,
    output cand_t out_cand
);

    half_t left_h;  // Upper half of the incoming block
    half_t right_h; // Lower half
    half_t f_out;   // Round function result

    // Key mix, then add a rotated copy of itself
    function automatic half_t round_f(input half_t r, input half_t k);
        half_t t;
        half_t t_rot;
        t     = r ^ k;
        t_rot = {t[`HALF_W-`ROT_AMT-1:0], t[`HALF_W-1:`HALF_W-`ROT_AMT]};
        return t + t_rot; // Wraps modulo 2^HALF_W
    endfunction

    assign left_h  = in_cand.blk[`SEARCH_W-1:`HALF_W];
    assign right_h = in_cand.blk[`HALF_W-1:0];
    assign f_out   = round_f(right_h, round_key);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_cand.valid <= 1'b0;
        end else begin
            out_cand.valid <= in_cand.valid;
        end
    end

    // Payload, follows valid
    always_ff @(posedge clk) begin
        out_cand.last <= in_cand.last;
        out_cand.msg  <= in_cand.msg;
        out_cand.blk  <= {right_h, left_h ^ f_out}; // Swap halves
    end

    // Exactly one cycle through this stage, nothing dropped or created
    a_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_cand.valid == $past(in_cand.valid)
    ) else $error("feistel_round valid out of step with its input");

endmodule

// File: logic/match_stage.sv
`timescale 1ns/100ps

// Compares the enciphered block with the target and keeps the search status
module match_stage
    import search_data_pkg::*, search_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           reset_counter, // Clears counters and done
    input  logic           start,         // New search, also clears
    input  block_t         target,
    input  cand_t          in_cand,
    output logic           hit,           // One cycle pulse
    output block_t         hit_msg,       // Valid together with hit
    output search_status_t status
);

    logic is_match; // Valid candidate equal to the target
    logic clear;

    assign is_match = in_cand.valid && (in_cand.blk == target);
    assign clear    = start | reset_counter;

    always_ff @(posedge clk) begin // Hit pulse
        if (!rst_n) begin
            hit <= 1'b0;
        end else begin
            hit <= is_match;
        end
    end

    always_ff @(posedge clk) begin
        if (is_match) begin
            hit_msg <= in_cand.msg; // Message that enciphers to the target
        end
    end

    always_ff @(posedge clk) begin // Status counters
        if (!rst_n) begin
            status <= '0;
        end else if (clear) begin
            status <= '0;
        end else if (in_cand.valid) begin
            status.tried <= status.tried + 1'b1;
            if (is_match) begin
                status.hits <= status.hits + 1'b1;
            end
            if (in_cand.last) begin
                status.done <= 1'b1; // Sticky until cleared
            end
        end
    end

    // A hit only follows a valid candidate one cycle earlier
    a_hit_has_cand: assert property (
        @(posedge clk) disable iff (!rst_n)
        hit |-> $past(in_cand.valid)
    ) else $error("match_stage hit without a valid candidate");

endmodule

// File: logic/search_top.sv
`timescale 1ns/100ps
`include "search_cfg.svh"

// Search pipeline: candidate source, two cipher rounds, match
// Three cycles from a candidate leaving the source to its match result
module search_top
    import search_data_pkg::*, search_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           pause,
    input  logic           reset_counter,
    input  block_t         seed,
    input  block_t         polynomial,
    input  block_t         key,
    input  block_t         target,       // Ciphertext to look for
    output logic           hit,
    output block_t         hit_msg,
    output search_status_t status,
    output cnt_state_e     cnt_state
);

    cand_t cand_src; // Counter to round 0
    cand_t cand_r0;  // Round 0 to round 1
    cand_t cand_r1;  // Round 1 to match

    half_t key_r0;
    half_t key_r1;

    assign key_r0 = key[`SEARCH_W-1:`HALF_W]; // Upper half first
    assign key_r1 = key[`HALF_W-1:0];

    lfsr_counter lfsr_counter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .pause         (pause),
        .reset_counter (reset_counter),
        .seed          (seed),
        .polynomial    (polynomial),
        .cand          (cand_src),
        .state         (cnt_state)
    );

    feistel_round round0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .round_key (key_r0),
        .in_cand   (cand_src),
        .out_cand  (cand_r0)
    );

    feistel_round round1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .round_key (key_r1),
        .in_cand   (cand_r0),
        .out_cand  (cand_r1)
    );

    match_stage match_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .reset_counter (reset_counter),
        .start         (start),
        .target        (target),
        .in_cand       (cand_r1),
        .hit           (hit),
        .hit_msg       (hit_msg),
        .status        (status)
    );

endmodule

// File: bench/search_tb.sv
`timescale 1ns/100ps
`include "search_cfg.svh"

// Testbench for the candidate search engine
// Each table entry runs one full LFSR period through the DUT against a model
module search_tb
    import search_data_pkg::*, search_ctrl_pkg::*;
();

    localparam int NUM_ENTRIES = 8;
    localparam int MAX_PERIOD  = 256; // Model gives up beyond this

    typedef struct packed {
        block_t seed;
        block_t poly;
        block_t key;
        int     target_sel; // Period index where -1 means a target outside the period
        logic   use_pause;  // Random pause pulses during the run
        logic   do_abort;   // Abort once mid-run and then start again
    } entry_t;

    logic           clk;
    logic           rst_n;
    logic           start;
    logic           pause;
    logic           reset_counter;
    block_t         seed;
    block_t         polynomial;
    block_t         key;
    block_t         target;
    logic           hit;
    block_t         hit_msg;
    search_status_t status;
    cnt_state_e     cnt_state;

    entry_t table_e [NUM_ENTRIES];
    block_t period_q [$]; // Expected candidates in issue order

    search_top search_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .pause         (pause),
        .reset_counter (reset_counter),
        .seed          (seed),
        .polynomial    (polynomial),
        .key           (key),
        .target        (target),
        .hit           (hit),
        .hit_msg       (hit_msg),
        .status        (status),
        .cnt_state     (cnt_state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    // Zero polynomials rotate right, so periods follow from the seed pattern
    task automatic fill_table();
        table_e[0] = '{64'h0101_0101_0101_0101, 64'h0, 64'h0123_4567_89AB_CDEF, 3, 1'b0, 1'b0};
        table_e[1] = '{64'h5555_5555_5555_5555, 64'h0, 64'hDEAD_BEEF_CAFE_F00D, -1, 1'b0, 1'b0};
        table_e[2] = '{64'h1111_1111_1111_1111, 64'h0, 64'h0F1E_2D3C_4B5A_6978, 0, 1'b1, 1'b0};
        table_e[3] = '{64'h00FF_00FF_00FF_00FF, 64'h0, 64'h1357_9BDF_2468_ACE0, 11, 1'b1, 1'b0};
        table_e[4] = '{64'h0000_0000_FFFF_FFFF, 64'h0, 64'hA5A5_5A5A_3C3C_C3C3, 40, 1'b0, 1'b1};
        table_e[5] = '{64'h0, 64'h0, 64'h7777_0000_8888_FFFF, 0, 1'b0, 1'b0}; // Period of one
        table_e[6] = '{64'h0, 64'h0, 64'h0000_1111_2222_3333, -1, 1'b1, 1'b0};
        table_e[7] = '{64'h0F0F_0F0F_0F0F_0F0F, 64'h0, 64'hFEDC_BA98_7654_3210, 7, 1'b1, 1'b1};
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "search_tb stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure("Value mismatch");
        end
    endtask

    // Shift right with bit 0 folded back into the MSB and every tapped position
    function automatic block_t lfsr_successor(input block_t cur, input block_t poly);
        block_t taps;
        taps = {1'b1, poly[`SEARCH_W-2:0]};
        return cur[0] ? ((cur >> 1) ^ taps) : (cur >> 1);
    endfunction

    function automatic half_t round_mix(input half_t r, input half_t k);
        half_t t;
        t = r ^ k;
        return t + ((t << `ROT_AMT) | (t >> (`HALF_W - `ROT_AMT))); // Mod 2^HALF_W
    endfunction

    // Two rounds with the upper key half first
    function automatic block_t encipher_two_rounds(input block_t m, input block_t k);
        half_t l;
        half_t r;
        half_t tmp;
        l   = m[`SEARCH_W-1:`HALF_W];
        r   = m[`HALF_W-1:0];
        tmp = r;
        r   = l ^ round_mix(r, k[`SEARCH_W-1:`HALF_W]);
        l   = tmp;
        tmp = r;
        r   = l ^ round_mix(r, k[`HALF_W-1:0]);
        l   = tmp;
        return {l, r};
    endfunction

    task automatic build_period(input block_t seed_v, input block_t poly_v);
        block_t cur;
        period_q.delete();
        cur = seed_v;
        do begin
            period_q.push_back(cur);
            cur = lfsr_successor(cur, poly_v);
        end while (cur != seed_v && period_q.size() < MAX_PERIOD);
        if (cur != seed_v) begin
            stop_with_failure("Model period is longer than the table allows");
        end
    endtask

    // First block above the inverted seed that never shows up in the period
    function automatic block_t outside_value(input block_t seed_v);
        block_t v;
        logic   found;
        v = ~seed_v;
        for (int n = 0; n <= MAX_PERIOD; n++) begin
            found = 1'b0;
            foreach (period_q[j]) begin
                if (period_q[j] == v) begin
                    found = 1'b1;
                end
            end
            if (!found) begin
                return v;
            end
            v = v + 1'b1;
        end
        return v;
    endfunction

    task automatic start_search();
        @(posedge clk);
        start <= 1'b1; // One cycle pulse that also clears the status
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
    endtask

    // Held four cycles so the three pipeline stages drain under the clear
    task automatic abort_search();
        @(posedge clk);
        reset_counter <= 1'b1;
        repeat (4) @(posedge clk);
        reset_counter <= 1'b0;
        repeat (2) @(negedge clk);
        check_value("cnt_state", 64'(cnt_state), 64'(cnt_idle));
        check_value("status.tried", 64'(status.tried), 64'd0);
        check_value("status.hits", 64'(status.hits), 64'd0);
        check_value("status.done", 64'(status.done), 64'd0);
    endtask

    task automatic wait_tried(input int count, input int limit);
        int cycles;
        for (cycles = 0; cycles < limit && status.tried < count; cycles++) begin
            @(negedge clk);
        end
        if (status.tried < count) begin
            stop_with_failure("Timeout waiting for the first candidates to be compared");
        end
    endtask

    // Counts hit pulses until done and pauses at random on request
    task automatic run_until_done(input logic use_pause, input int limit,
                                  output int pulses, output block_t seen_msg);
        int cycles;
        int pause_left;
        pulses     = 0;
        seen_msg   = '0;
        pause_left = 0;
        for (cycles = 0; cycles < limit && !status.done; cycles++) begin
            @(posedge clk);
            if (use_pause && pause_left == 0 && ($urandom % 4) == 0) begin
                pause_left = 1 + int'($urandom % 4); // 1 to 4 cycles
            end
            pause <= (pause_left > 0);
            if (pause_left > 0) begin
                pause_left--;
            end
            @(negedge clk);
            if (hit) begin
                pulses++;
                seen_msg = hit_msg; // Sampled with the pulse
            end
        end
        if (!status.done) begin
            stop_with_failure("Timeout waiting for status.done after start");
        end
    endtask

    initial begin
        entry_t e;
        block_t exp_msg;
        block_t seen_msg;
        int     exp_hits;
        int     pulses;
        int     limit;

        void'($urandom(30636));
        fill_table();

        rst_n         = 1'b0;
        start         = 1'b0;
        pause         = 1'b0;
        reset_counter = 1'b0;
        seed          = '0;
        polynomial    = '0;
        key           = '0;
        target        = '0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("hit", 64'(hit), 64'd0);
        check_value("status.done", 64'(status.done), 64'd0);
        check_value("status.tried", 64'(status.tried), 64'd0);
        check_value("status.hits", 64'(status.hits), 64'd0);
        check_value("cnt_state", 64'(cnt_state), 64'(cnt_idle));

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = table_e[i];
            build_period(e.seed, e.poly);
            if (e.target_sel >= period_q.size()) begin
                stop_with_failure("Table target index lies beyond the period");
            end
            if (e.target_sel >= 0) begin
                exp_msg  = period_q[e.target_sel];
                exp_hits = 1;
            end else begin
                exp_msg  = outside_value(e.seed); // Cipher is a permutation so this never matches
                exp_hits = 0;
            end
            limit = 8 * period_q.size() + 40; // Room for pauses

            @(posedge clk);
            seed       <= e.seed;
            polynomial <= e.poly;
            key        <= e.key;
            target     <= encipher_two_rounds(exp_msg, e.key);
            start_search();

            if (e.do_abort) begin
                wait_tried(2, limit);
                check_value("status.done", 64'(status.done), 64'd0); // Still mid-run
                abort_search();
                start_search();
            end

            run_until_done(e.use_pause, limit, pulses, seen_msg);
            check_value("status.tried", 64'(status.tried), 64'(period_q.size()));
            check_value("status.hits", 64'(status.hits), 64'(exp_hits));
            check_value("hit pulses", 64'(pulses), 64'(exp_hits));
            if (exp_hits == 1) begin
                check_value("hit_msg", seen_msg, exp_msg);
            end

            for (int c = 0; c < 5; c++) begin // Nothing may follow the last candidate
                @(posedge clk);
                pause <= 1'b0;
                @(negedge clk);
                if (hit) begin
                    pulses++;
                end
            end
            check_value("cnt_state", 64'(cnt_state), 64'(cnt_finished));
            check_value("status.tried", 64'(status.tried), 64'(period_q.size()));
            check_value("status.done", 64'(status.done), 64'd1);
            check_value("hit pulses", 64'(pulses), 64'(exp_hits));

            abort_search(); // Back to idle for the next entry
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: flist.f
+incdir+logic
logic/search_data_pkg.sv
logic/search_ctrl_pkg.sv
logic/lfsr_counter.sv
logic/feistel_round.sv
logic/match_stage.sv
logic/search_top.sv
bench/search_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the search engine testbench with Verilator, run it, and grep the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module search_tb \
    -f flist.f -o search_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
{ ./obj_dir/search_sim > sim.log 2>&1 || true; } \
    && grep -q "^>>> PASS$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
